//--- flist.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpu_tb simulation with Verilator, then grep the log for the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f flist.f \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vcpu_tb > sim.log 2>&1 || echo "Simulator returned a failing status"

grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- tests/cpu_tb.sv
// Random-program testbench for cpu_top, checked against an instruction-level model
// Programs branch forward only and end in HALT, so the model always terminates
// Loads and stores use R0 as base and stay within data words 0 to 7
`default_nettype none
`timescale 1ns/100ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int IMEM_AW  = 8;
	localparam int DMEM_AW  = 4;
	localparam int N_RAND   = 60;
	localparam int PROG_LEN = 8 + N_RAND + 1;
	localparam int TIMEOUT  = 2000;

	logic               clk;
	logic               rst_n;
	logic               run;
	logic               prog_we;
	logic [IMEM_AW-1:0] prog_addr;
	word_t              prog_data;
	logic               retire_valid;
	retire_t            retire;
	logic               halted;

	integer  seed;
	int      errors;
	int      cycles;
	word_t   prog [PROG_LEN];
	retire_t expected [$];

	cpu_top #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.prog_we      (prog_we),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	function automatic word_t encode(input logic [4:0] op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [4:0] low);
		return {op, rs, rt, low};
	endfunction

	function automatic word_t sext5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic word_t sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	task automatic build_program();
		reg_idx_t   prev_dest;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] op;
		logic [7:0] imm8;
		int         kind;
		int         pos;
		int         max_skip;
		prev_dest = 3'd0;
		// Clear data words 0 to 7
		for (int i = 0; i < 8; i++) begin
			prog[i] = encode(OP_ST, 3'd0, 3'd0, 5'(2 * i));
		end
		for (int i = 0; i < N_RAND; i++) begin
			pos  = 8 + i;
			kind = rand_below(10);
			rs   = reg_idx_t'(rand_below(8));
			rt   = reg_idx_t'(rand_below(8));
			rd   = reg_idx_t'(1 + rand_below(7));
			// Reuse the last result often to hit forwarding and load-use
			if (prev_dest != 3'd0 && rand_below(2) == 0) begin
				rs = prev_dest;
			end
			prev_dest = 3'd0;
			// Branch target may land on HALT but never beyond it
			max_skip = PROG_LEN - 2 - pos;
			if (max_skip > 4) begin
				max_skip = 4;
			end
			case (kind)
				0, 1, 2: begin
					prog[pos] = encode(OP_ALU, rs, rt, {rd, 2'(rand_below(4))});
					prev_dest = rd;
				end
				3: begin
					prog[pos] = encode(OP_ADDI, rs, rd, 5'(rand_below(32)));
					prev_dest = rd;
				end
				4: begin
					imm8      = 8'(rand_below(256));
					prog[pos] = encode(OP_LBI, rd, imm8[7:5], imm8[4:0]);
					prev_dest = rd;
				end
				5: begin
					prog[pos] = encode(OP_LD, 3'd0, rd, 5'(2 * rand_below(8)));
					prev_dest = rd;
				end
				6: begin
					prog[pos] = encode(OP_ST, 3'd0, rt, 5'(2 * rand_below(8)));
				end
				7: begin
					if (max_skip >= 1) begin
						imm8      = 8'(2 * (1 + rand_below(max_skip)));
						op        = (rand_below(2) != 0) ? OP_BEQZ : OP_BNEZ;
						prog[pos] = encode(op, rs, imm8[7:5], imm8[4:0]);
					end else begin
						prog[pos] = encode(OP_NOP, 3'd0, 3'd0, 5'd0);
					end
				end
				default: begin
					prog[pos] = encode(OP_NOP, 3'd0, 3'd0, 5'd0);
				end
			endcase
		end
		prog[PROG_LEN-1] = encode(OP_HALT, 3'd0, 3'd0, 5'd0);
	endtask

	// Sequential interpreter, one expected retire per executed instruction
	task automatic run_model();
		word_t      regs [8];
		word_t      dmem [16];
		word_t      pc;
		word_t      instr;
		word_t      a;
		word_t      b;
		word_t      addr;
		retire_t    ev;
		logic [4:0] op;
		logic       done;
		int         steps;
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 16; i++) begin
			dmem[i] = '0;
		end
		pc    = 16'h0000;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < PROG_LEN) begin
			instr   = prog[pc[IMEM_AW:1]];
			op      = instr[15:11];
			a       = regs[instr[10:8]];
			b       = regs[instr[7:5]];
			ev      = '0;
			ev.pc   = pc;
			pc      = pc + 16'd2;
			case (op)
				OP_ALU: begin
					ev.reg_write = 1'b1;
					ev.dest      = instr[4:2];
					case (instr[1:0])
						2'b00:   ev.data = a + b;
						2'b01:   ev.data = a - b;
						2'b10:   ev.data = a ^ b;
						default: ev.data = a & ~b;
					endcase
				end
				OP_ADDI: begin
					ev.reg_write = 1'b1;
					ev.dest      = instr[7:5];
					ev.data      = a + sext5(instr[4:0]);
				end
				OP_LBI: begin
					ev.reg_write = 1'b1;
					ev.dest      = instr[10:8];
					ev.data      = sext8(instr[7:0]);
				end
				OP_LD: begin
					addr         = a + sext5(instr[4:0]);
					ev.reg_write = 1'b1;
					ev.dest      = instr[7:5];
					ev.data      = dmem[addr[4:1]];
				end
				OP_ST: begin
					addr             = a + sext5(instr[4:0]);
					dmem[addr[4:1]]  = b;
				end
				OP_BEQZ: begin
					if (a == 16'h0000) begin
						pc = pc + sext8(instr[7:0]);
					end
				end
				OP_BNEZ: begin
					if (a != 16'h0000) begin
						pc = pc + sext8(instr[7:0]);
					end
				end
				OP_HALT: begin
					done = 1'b1;
				end
				default: begin
				end
			endcase
			if (ev.reg_write) begin
				regs[ev.dest] = ev.data;
			end
			expected.push_back(ev);
			steps++;
		end
	endtask

	task automatic compare_field(input string name, input word_t want, input word_t got);
		assert (want == got) else begin
			$display("Fail time=%0t %s expected=%h actual=%h", $time, name, want, got);
			errors++;
		end
	endtask

	// Retire port sampled at the falling edge, in program order
	always @(negedge clk) begin : retire_check
		retire_t want;
		if (rst_n && retire_valid) begin
			assert (expected.size() > 0) else begin
				$display("Instruction retired at time %0t after the program had ended", $time);
				errors++;
			end
			if (expected.size() > 0) begin
				want = expected.pop_front();
				compare_field("retire.pc", want.pc, retire.pc);
				compare_field("retire.reg_write", 16'(want.reg_write), 16'(retire.reg_write));
				if (want.reg_write) begin
					compare_field("retire.dest", 16'(want.dest), 16'(retire.dest));
					compare_field("retire.data", want.data, retire.data);
				end
			end
		end
	end

	initial begin
		seed      = 96;
		errors    = 0;
		rst_n     = 1'b0;
		run       = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		build_program();
		run_model();
		repeat (10) @(posedge clk);
		#10;
		rst_n = 1'b1;
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge clk);
			#10;
			prog_we   = 1'b1;
			prog_addr = IMEM_AW'(i);
			prog_data = prog[i];
		end
		@(posedge clk);
		#10;
		prog_we = 1'b0;
		run     = 1'b1;
		cycles  = 0;
		while (expected.size() != 0 && cycles < TIMEOUT) begin
			@(posedge clk);
			#10;
			cycles++;
		end
		if (expected.size() != 0) begin
			$display("Timeout with %0d instructions still to retire", expected.size());
			errors++;
		end else begin
			cycles = 0;
			while (!halted && cycles < TIMEOUT) begin
				@(posedge clk);
				#10;
				cycles++;
			end
			assert (halted) else begin
				$display("Timeout waiting for halted after HALT retired");
				errors++;
			end
			// halted must hold and nothing may retire afterwards
			repeat (20) begin
				@(posedge clk);
				#10;
				assert (halted) else begin
					$display("halted dropped at time %0t without a reset", $time);
					errors++;
				end
			end
		end
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/cpu_sva.sv
// Retire port and halt checks, bound into cpu_top
// halted is taken to stay high until the next reset
`default_nettype none
`timescale 1ns/100ps

module cpu_sva (
	input logic clk,
	input logic rst_n,
	input logic retire_valid,
	input logic halted
);

	// Reset clears the retire strobe
	a_no_retire_in_reset: assert property (@(posedge clk) !rst_n |=> !retire_valid)
		else $error("retire_valid high during reset");

	a_halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted dropped without a reset");

	// The pipe is drained well before this point
	a_quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
		halted && $past(halted, 4) |-> !retire_valid)
		else $error("retire_valid after halted was high for more than four cycles");

endmodule

bind cpu_top cpu_sva u_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.retire_valid (retire_valid),
	.halted       (halted)
);

`default_nettype wire

//--- source/cpu_top.sv
// Five-stage in-order 16-bit core
// Hold run low while loading the program through prog_we
// retire_valid pulses once per completed instruction with no back-pressure
// IMEM_AW and DMEM_AW set the memory sizes and neither may exceed 15
`default_nettype none
`timescale 1ns/100ps

module cpu_top #(
	parameter int IMEM_AW = 8,
	parameter int DMEM_AW = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               run,
	input  logic               prog_we,
	input  logic [IMEM_AW-1:0] prog_addr,
	input  cpu_pkg::word_t     prog_data,
	output logic               retire_valid,
	output cpu_pkg::retire_t   retire,
	output logic               halted
);
	import cpu_pkg::*;

	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	fwd_t    mem_fwd;
	wb_t     wb;
	word_t   branch_target;
	logic    stall;
	logic    flush;

	fetch_stage #(.IMEM_AW(IMEM_AW)) u_fetch (
		.clk           (clk),
		.rst_n         (rst_n),
		.run           (run),
		.prog_we       (prog_we),
		.prog_addr     (prog_addr),
		.prog_data     (prog_data),
		.stall         (stall),
		.flush         (flush),
		.branch_target (branch_target),
		.if_id         (if_id)
	);

	decode_stage u_decode (
		.clk   (clk),
		.rst_n (rst_n),
		.if_id (if_id),
		.flush (flush),
		.wb    (wb),
		.id_ex (id_ex),
		.stall (stall)
	);

	// EX/MEM bypass loops inside execute and MEM/WB comes back from memory
	execute_stage u_execute (
		.clk           (clk),
		.rst_n         (rst_n),
		.id_ex         (id_ex),
		.mem_fwd       (mem_fwd),
		.ex_mem        (ex_mem),
		.flush         (flush),
		.branch_target (branch_target),
		.ex_fwd        ()
	);

	memory_stage #(.DMEM_AW(DMEM_AW)) u_memory (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex_mem       (ex_mem),
		.mem_fwd      (mem_fwd),
		.wb           (wb),
		.retire_valid (retire_valid),
		.retire       (retire),
		.halted       (halted)
	);

endmodule

`default_nettype wire

//--- source/memory_stage.sv
// Data memory access, MEM/WB register, writeback select and retire report
// Data memory holds 2**DMEM_AW words, reads are combinational and it has no reset
// DMEM_AW may be at most 15 and higher address bits wrap
// halted is sticky until reset once HALT retires
`default_nettype none
`timescale 1ns/100ps

module memory_stage #(
	parameter int DMEM_AW = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::fwd_t    mem_fwd,
	output cpu_pkg::wb_t     wb,
	output logic             retire_valid,
	output cpu_pkg::retire_t retire,
	output logic             halted
);
	import cpu_pkg::*;

	word_t              dmem [2**DMEM_AW];
	logic [DMEM_AW-1:0] daddr;
	word_t              load_data;
	word_t              wb_data;
	logic               halt_q;

	assign daddr     = ex_mem.result[DMEM_AW:1];
	assign load_data = dmem[daddr];
	assign wb_data   = ex_mem.ctrl.mem_read ? load_data : ex_mem.result;

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.ctrl.mem_write) begin
			dmem[daddr] <= ex_mem.store_data;
		end
	end

	// MEM/WB doubles as the retire report
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			halt_q       <= 1'b0;
			halted       <= 1'b0;
		end else begin
			retire_valid     <= ex_mem.valid;
			halt_q           <= ex_mem.valid && ex_mem.ctrl.is_halt;
			retire.pc        <= ex_mem.pc;
			retire.reg_write <= ex_mem.ctrl.reg_write;
			retire.dest      <= ex_mem.ctrl.dest;
			retire.data      <= wb_data;
			if (halt_q) begin
				halted <= 1'b1;
			end
		end
	end

	// Bypass to execute and the register file write
	always_comb begin
		mem_fwd.valid     = retire_valid;
		mem_fwd.reg_write = retire.reg_write;
		mem_fwd.dest      = retire.dest;
		mem_fwd.value     = retire.data;
		wb.we             = retire_valid && retire.reg_write;
		wb.dest           = retire.dest;
		wb.data           = retire.data;
	end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// Execute with operand forwarding, the ALU, branch resolution and EX/MEM
// Branches are resolved here and a taken one flushes the two younger slots
// Loads in EX/MEM are never forwarded since their data is not yet read
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  cpu_pkg::id_ex_t  id_ex,
	input  cpu_pkg::fwd_t    mem_fwd,
	output cpu_pkg::ex_mem_t ex_mem,
	output logic             flush,
	output cpu_pkg::word_t   branch_target,
	output cpu_pkg::fwd_t    ex_fwd
);
	import cpu_pkg::*;

	word_t op_a;
	word_t rt_fwd;
	word_t op_b;
	word_t result;

	// Newest producer wins
	function automatic word_t fwd_pick(
		input reg_idx_t idx,
		input word_t    rf_val,
		input fwd_t     near,
		input fwd_t     far
	);
		if (near.valid && near.reg_write && near.dest == idx) begin
			return near.value;
		end else if (far.valid && far.reg_write && far.dest == idx) begin
			return far.value;
		end
		return rf_val;
	endfunction

	// EX/MEM bypass source
	always_comb begin
		ex_fwd.valid     = ex_mem.valid;
		ex_fwd.reg_write = ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read;
		ex_fwd.dest      = ex_mem.ctrl.dest;
		ex_fwd.value     = ex_mem.result;
	end

	assign op_a   = fwd_pick(id_ex.rs_idx, id_ex.rs_val, ex_fwd, mem_fwd);
	assign rt_fwd = fwd_pick(id_ex.rt_idx, id_ex.rt_val, ex_fwd, mem_fwd);
	assign op_b   = id_ex.ctrl.use_imm ? id_ex.imm : rt_fwd;

	// Also forms the LD and ST address
	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_XOR: result = op_a ^ op_b;
			default: result = op_a & ~op_b;
		endcase
		if (id_ex.ctrl.is_lbi) begin
			result = id_ex.imm;
		end
	end

	// Branch test on forwarded Rs
	assign flush = id_ex.valid && id_ex.ctrl.is_branch &&
	               ((op_a == '0) == id_ex.ctrl.branch_on_zero);
	assign branch_target = id_ex.pc_next + id_ex.imm;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.valid <= 1'b0;
		end else begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.pc         <= id_ex.pc;
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.result     <= result;
			ex_mem.store_data <= rt_fwd;
		end
	end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// Decode with the register file, load-use detection and the ID/EX register
// Register writes land in the writeback cycle and bypass to same-cycle reads
// A load in ID/EX whose dest is read here costs one bubble
// Unknown opcodes decode as NOP
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  cpu_pkg::if_id_t if_id,
	input  logic            flush,
	input  cpu_pkg::wb_t    wb,
	output cpu_pkg::id_ex_t id_ex,
	output logic            stall
);
	import cpu_pkg::*;

	word_t    regs [8];
	opcode_e  opcode;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	ctrl_t    ctrl;
	word_t    imm;
	logic     imm8_sel;
	logic     uses_rs;
	logic     uses_rt;
	word_t    rs_val;
	word_t    rt_val;
	logic     hazard_rs;
	logic     hazard_rt;

	assign opcode = opcode_e'(if_id.instr[15:11]);
	assign rs     = if_id.instr[10:8];
	assign rt     = if_id.instr[7:5];
	assign rd     = if_id.instr[4:2];

	// Register file
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// Write-through so a same-cycle writeback is seen
	assign rs_val = (wb.we && wb.dest == rs) ? wb.data : regs[rs];
	assign rt_val = (wb.we && wb.dest == rt) ? wb.data : regs[rt];

	// LBI and branches take the 8-bit field
	assign imm8_sel = (opcode == OP_LBI) || (opcode == OP_BEQZ) || (opcode == OP_BNEZ);
	assign imm = imm8_sel ? {{8{if_id.instr[7]}}, if_id.instr[7:0]}
	                      : {{11{if_id.instr[4]}}, if_id.instr[4:0]};

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = ALU_ADD;
		uses_rs     = 1'b0;
		uses_rt     = 1'b0;
		case (opcode)
			OP_ALU: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = alu_op_e'(if_id.instr[1:0]);
				ctrl.dest      = rd;
				uses_rs        = 1'b1;
				uses_rt        = 1'b1;
			end
			OP_ADDI: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.dest      = rt;
				uses_rs        = 1'b1;
			end
			OP_LD: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.dest      = rt;
				uses_rs        = 1'b1;
			end
			OP_ST: begin
				// Rt holds the store data
				ctrl.mem_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				uses_rs        = 1'b1;
				uses_rt        = 1'b1;
			end
			OP_LBI: begin
				ctrl.reg_write = 1'b1;
				ctrl.is_lbi    = 1'b1;
				ctrl.dest      = rs;
			end
			OP_BEQZ: begin
				ctrl.is_branch      = 1'b1;
				ctrl.branch_on_zero = 1'b1;
				uses_rs             = 1'b1;
			end
			OP_BNEZ: begin
				ctrl.is_branch = 1'b1;
				uses_rs        = 1'b1;
			end
			OP_HALT: begin
				ctrl.is_halt = 1'b1;
			end
			default: begin
				// NOP
			end
		endcase
	end

	// Load-use against the instruction now in execute
	assign hazard_rs = uses_rs && (id_ex.ctrl.dest == rs);
	assign hazard_rt = uses_rt && (id_ex.ctrl.dest == rt);
	assign stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read && (hazard_rs || hazard_rt);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex.valid   <= if_id.valid && !flush && !stall;
			id_ex.pc      <= if_id.pc_next - 16'd2;
			id_ex.pc_next <= if_id.pc_next;
			id_ex.ctrl    <= ctrl;
			id_ex.rs_idx  <= rs;
			id_ex.rt_idx  <= rt;
			id_ex.rs_val  <= rs_val;
			id_ex.rt_val  <= rt_val;
			id_ex.imm     <= imm;
		end
	end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
// Instruction fetch with on-chip program memory and the IF/ID register
// Load through prog_we only while run is low, and memory is not cleared by reset
// IMEM_AW may be at most 15 since the word index is PC bits IMEM_AW:1
// After a HALT is fetched, fetch idles until a branch flush or reset
`default_nettype none
`timescale 1ns/100ps

module fetch_stage #(
	parameter int IMEM_AW = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               run,
	input  logic               prog_we,
	input  logic [IMEM_AW-1:0] prog_addr,
	input  cpu_pkg::word_t     prog_data,
	input  logic               stall,
	input  logic               flush,
	input  cpu_pkg::word_t     branch_target,
	output cpu_pkg::if_id_t    if_id
);
	import cpu_pkg::*;

	word_t imem [2**IMEM_AW];
	word_t pc;
	word_t pc_plus2;
	word_t instr;
	logic  halt_seen;
	logic  fetch_en;

	assign instr    = imem[pc[IMEM_AW:1]];
	assign pc_plus2 = pc + 16'd2;
	assign fetch_en = run && !halt_seen && !stall;

	// Program load port
	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= RESET_PC;
			halt_seen   <= 1'b0;
			if_id.valid <= 1'b0;
		end else if (flush) begin
			// Redirect and squash the wrong-path fetch
			pc          <= branch_target;
			halt_seen   <= 1'b0;
			if_id.valid <= 1'b0;
		end else if (fetch_en) begin
			if_id.valid   <= 1'b1;
			if_id.pc_next <= pc_plus2;
			if_id.instr   <= instr;
			// PC parks on HALT
			if (opcode_e'(instr[15:11]) == OP_HALT) begin
				halt_seen <= 1'b1;
			end else begin
				pc <= pc_plus2;
			end
		end else if (!stall) begin
			if_id.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
// Shared types for the 16-bit five-stage pipelined core
// Instruction fields are opcode 15:11, Rs 10:8, Rt 7:5, Rd 4:2 and funct 1:0
// Opcodes outside opcode_e decode as NOP
// Addresses are byte addresses and bit 0 is ignored by both memories
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0]  reg_idx_t;

	localparam word_t RESET_PC = 16'h0000;

	typedef enum logic [4:0] {
		OP_HALT = 5'b00000,
		OP_NOP  = 5'b00001,
		OP_ADDI = 5'b01000,
		OP_BEQZ = 5'b01100,
		OP_BNEZ = 5'b01101,
		OP_ST   = 5'b10000,
		OP_LD   = 5'b10001,
		OP_LBI  = 5'b11000,
		OP_ALU  = 5'b11011
	} opcode_e;

	// Register ALU ops by funct
	// SUB gives Rs minus Rt and ANDN gives Rs and not Rt
	typedef enum logic [1:0] {
		ALU_ADD  = 2'b00,
		ALU_SUB  = 2'b01,
		ALU_XOR  = 2'b10,
		ALU_ANDN = 2'b11
	} alu_op_e;

	typedef struct packed {
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     use_imm;
		logic     is_branch;
		logic     branch_on_zero;
		logic     is_lbi;
		logic     is_halt;
		alu_op_e  alu_op;
		reg_idx_t dest;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		word_t pc_next;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    pc_next;
		ctrl_t    ctrl;
		reg_idx_t rs_idx;
		reg_idx_t rt_idx;
		word_t    rs_val;
		word_t    rt_val;
		word_t    imm;
	} id_ex_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		ctrl_t ctrl;
		word_t result;
		word_t store_data;
	} ex_mem_t;

	typedef struct packed {
		word_t    pc;
		logic     reg_write;
		reg_idx_t dest;
		word_t    data;
	} retire_t;

	// Result offered to execute for operand bypass
	typedef struct packed {
		logic     valid;
		logic     reg_write;
		reg_idx_t dest;
		word_t    value;
	} fwd_t;

	typedef struct packed {
		logic     we;
		reg_idx_t dest;
		word_t    data;
	} wb_t;

endpackage

`default_nettype wire
